/* rv_mini.f */
+incdir+hw
hw/rv_mini_pkg.sv
hw/rv_mini_decode.sv
hw/rv_mini_regfile.sv
hw/rv_mini_alu.sv
hw/rv_mini_fetch.sv
hw/rv_mini_store.sv
hw/rv_mini_top.sv
dv/rv_mini_asserts.sv
dv/rv_mini_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_mini testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv_mini.f --top-module rv_mini_tb -o rv_mini_sim

./obj_dir/rv_mini_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* dv/rv_mini_tb.sv */
`timescale 1ns/1ps

`include "rv_mini_params.svh"

module rv_mini_tb;

    localparam int PROG_WORDS  = 256;
    localparam int CYCLE_LIMIT = 2 * PROG_WORDS + 50;

    logic                    clk;
    logic                    rst_n;
    rv_mini_pkg::word_t      pc;
    rv_mini_pkg::word_t      inst;
    rv_mini_pkg::store_req_t store_req;
    logic                    store_en;
    logic                    ecall;
    logic                    illegal;
    logic                    halted;

    logic [31:0] prog_mem [PROG_WORDS];
    logic [31:0] dmem [256];      // reference memory, 1 KB window
    logic [31:0] dut_mem [256];   // built from the DUT store port
    logic [31:0] regs [32];
    logic [31:0] iss_pc;
    logic        iss_halted;
    logic [31:0] lcg_state;
    logic [31:0] mask;
    logic        run_reported;
    int          cycles;

    rv_mini_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .inst      (inst),
        .store_req (store_req),
        .store_en  (store_en),
        .ecall     (ecall),
        .illegal   (illegal),
        .halted    (halted)
    );

    bind rv_mini_top rv_mini_asserts asserts_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .store_req (store_req),
        .store_en  (store_en),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            run_reported = 1'b1;
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    // stores always use x0 as base, so the address is the offset
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] f;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          hop;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            r   = lcg_next();
            f   = lcg_next();
            f3  = f[17:15];
            imm = f[29:18];
            case (r[27:24])
                4'd4, 4'd5, 4'd6: begin
                    f7 = (f[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                    prog_mem[i] = enc_r(f7, f[14:10], f[9:5], f3, f[4:0]);
                end
                4'd7: prog_mem[i] = {f[31:12], f[4:0], 7'h37};  // lui
                4'd8: prog_mem[i] = {f[31:12], f[4:0], 7'h17};  // auipc
                4'd9: begin
                    hop = 2 + int'(f[20:18]) % 6;  // short forward jump
                    if (i + hop > PROG_WORDS - 1) begin
                        hop = PROG_WORDS - 1 - i;
                    end
                    prog_mem[i] = enc_j(21'(hop * 4), f[4:0]);
                end
                4'd10, 4'd11, 4'd12: begin
                    if (f[16:15] == 2'd0) begin
                        prog_mem[i] = enc_s({2'b0, f[27:18]}, f[14:10], 3'd0);
                    end else if (f[16:15] == 2'd1) begin
                        prog_mem[i] = enc_s({2'b0, f[27:19], 1'b0}, f[14:10], 3'd1);
                    end else begin
                        prog_mem[i] = enc_s({2'b0, f[27:20], 2'b0}, f[14:10], 3'd2);
                    end
                end
                4'd13: prog_mem[i] = 32'h0000_0073;
                4'd14: prog_mem[i] = {f[31:7], 7'h03};  // load opcode, not supported
                default: begin
                    if (f3 == 3'd1) begin
                        imm = {7'h00, f[22:18]};
                    end else if (f3 == 3'd5) begin
                        imm = {f[30] ? 7'h20 : 7'h00, f[22:18]};
                    end
                    prog_mem[i] = enc_i(imm, f[9:5], f3, f[4:0]);
                end
            endcase
        end
        // write to x0, then store x0
        for (int i = 20; i < PROG_WORDS - 10; i += 40) begin
            prog_mem[i]     = enc_i(12'h123, 5'd7, 3'd0, 5'd0);
            prog_mem[i + 1] = enc_s(12'(i * 4), 5'd0, 3'd2);
        end
        prog_mem[PROG_WORDS - 1] = 32'h0010_0073;  // ebreak
    endtask

    // reference step: compare this cycle's outputs, then retire the word
    task automatic iss_step(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] lanes;
        logic [3:0]  strb;
        logic        alt;
        logic        wr;
        logic        st;
        logic        ecl;
        logic        ill;
        opc     = w[6:0];
        f3      = w[14:12];
        a       = regs[w[19:15]];
        b       = regs[w[24:20]];
        alt     = w[30] && (f3 == 3'd5 || (opc == 7'h33 && f3 == 3'd0));
        res     = '0;
        addr    = '0;
        data    = '0;
        strb    = '0;
        wr      = 1'b0;
        st      = 1'b0;
        ecl     = 1'b0;
        ill     = 1'b0;
        next_pc = iss_pc + 32'd4;
        case (opc)
            7'h13: begin
                wr  = 1'b1;
                res = alu_ref(f3, alt, a, {{20{w[31]}}, w[31:20]});
            end
            7'h33: begin
                wr  = 1'b1;
                res = alu_ref(f3, alt, a, b);
            end
            7'h37: begin
                wr  = 1'b1;
                res = {w[31:12], 12'b0};
            end
            7'h17: begin
                wr  = 1'b1;
                res = iss_pc + {w[31:12], 12'b0};
            end
            7'h6f: begin
                wr      = 1'b1;
                res     = iss_pc + 32'd4;
                next_pc = iss_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h23: begin
                st   = 1'b1;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                case (f3)
                    3'd0: begin
                        strb = 4'b0001 << addr[1:0];
                        data = {4{b[7:0]}};
                    end
                    3'd1: begin
                        strb = 4'b0011 << addr[1:0];
                        data = {2{b[15:0]}};
                    end
                    default: begin
                        strb = 4'b1111;
                        data = b;
                    end
                endcase
            end
            7'h73: begin
                if (w == 32'h0010_0073) begin
                    iss_halted = 1'b1;
                    next_pc    = iss_pc;
                end else if (w == 32'h0000_0073) begin
                    ecl = 1'b1;
                end else begin
                    ill = 1'b1;
                end
            end
            default: ill = 1'b1;
        endcase
        check_equal("store_en", 32'(st), 32'(store_en));
        check_equal("ecall", 32'(ecl), 32'(ecall));
        check_equal("illegal", 32'(ill), 32'(illegal));
        if (st) begin
            lanes = lane_mask(strb);
            check_equal("store addr", addr, store_req.addr);
            check_equal("store wstrb", 32'(strb), 32'(store_req.wstrb));
            check_equal("store data", data & lanes, store_req.wdata & lanes);
            dmem[addr[9:2]] = (dmem[addr[9:2]] & ~lanes) | (data & lanes);
        end
        if (wr && w[11:7] != 5'd0) begin
            regs[w[11:7]] = res;
        end
        iss_pc = next_pc;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
            run_reported = 1'b1;
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n        = 1'b0;
        inst         = '0;
        lcg_state    = 32'hff4f;
        iss_pc       = `RV_MINI_RESET_PC;
        iss_halted   = 1'b0;
        run_reported = 1'b0;
        cycles       = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]    = '0;
            dut_mem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        gen_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (!iss_halted) begin
            check_equal("pc", iss_pc, pc);
            check_equal("halted", 32'd0, 32'(halted));
            inst = prog_mem[pc[9:2]];
            #2;  // let the combinational outputs settle
            if (store_en) begin
                mask = lane_mask(store_req.wstrb);
                dut_mem[store_req.addr[9:2]] = (dut_mem[store_req.addr[9:2]] & ~mask) |
                                               (store_req.wdata & mask);
            end
            iss_step(prog_mem[iss_pc[9:2]]);
            @(negedge clk);
        end
        check_equal("halted", 32'd1, 32'(halted));
        for (int k = 0; k < 10; k++) begin
            case (k % 4)
                0:       inst = 32'h0000_2023;        // sw x0, 0(x0)
                1:       inst = 32'h0000_0073;        // ecall
                2:       inst = 32'hffff_ffff;        // unknown opcode
                default: inst = enc_j(21'd8, 5'd1);   // jal must not move pc
            endcase
            #2;
            check_equal("halted pc", iss_pc, pc);
            check_equal("halted store_en", 32'd0, 32'(store_en));
            check_equal("halted ecall", 32'd0, 32'(ecall));
            check_equal("halted illegal", 32'd0, 32'(illegal));
            check_equal("halted", 32'd1, 32'(halted));
            @(negedge clk);
        end
        for (int i = 0; i < 256; i++) begin
            check_equal("data memory", dmem[i], dut_mem[i]);
        end
        run_reported = 1'b1;
        $display("=== PASS ===");
        $finish;
    end

    // a run stopped by an assertion never reaches the main sequence end
    final begin
        if (!run_reported) begin
            $display("=== FAIL ===");
        end
    end

endmodule

/* dv/rv_mini_asserts.sv */
`timescale 1ns/1ps

module rv_mini_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input rv_mini_pkg::dec_t       dec,
    input rv_mini_pkg::store_req_t store_req,
    input logic                    store_en,
    input logic                    halted
);

    // one lane for a byte, two adjacent (cut at the top) for a half, all for a word
    strobe_shape: assert property (@(posedge clk) disable iff (!rst_n)
        store_en |->
            (dec.store_size == rv_mini_pkg::BYTE && $countones(store_req.wstrb) == 1) ||
            (dec.store_size == rv_mini_pkg::HALF &&
             store_req.wstrb inside {4'b0011, 4'b0110, 4'b1100, 4'b1000}) ||
            (dec.store_size == rv_mini_pkg::WORD && store_req.wstrb == 4'b1111))
        else $error("store strobes do not fit the store size");

    // lowest enabled lane follows the address
    strobe_lane: assert property (@(posedge clk) disable iff (!rst_n)
        store_en && dec.store_size != rv_mini_pkg::WORD |->
            store_req.wstrb[store_req.addr[1:0]])
        else $error("store strobes miss the addressed byte");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without a reset");

    no_store_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !store_en)
        else $error("store offered while halted");

endmodule

/* hw/rv_mini_top.sv */
`timescale 1ns/1ps

module rv_mini_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output rv_mini_pkg::word_t      pc,
    input  rv_mini_pkg::word_t      inst,
    output rv_mini_pkg::store_req_t store_req,
    output logic                    store_en,
    output logic                    ecall,
    output logic                    illegal,
    output logic                    halted
);

    rv_mini_pkg::dec_t  dec;
    rv_mini_pkg::word_t rs1_data;
    rv_mini_pkg::word_t rs2_data;
    rv_mini_pkg::word_t alu_result;
    rv_mini_pkg::word_t wb_data;
    logic               reg_we;

    rv_mini_fetch u_fetch (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec),
        .pc     (pc),
        .halted (halted)
    );

    rv_mini_decode u_decode (
        .inst (inst),
        .dec  (dec)
    );

    rv_mini_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (reg_we),
        .rd       (dec.rd),
        .wdata    (wb_data)
    );

    rv_mini_alu u_alu (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    rv_mini_store u_store (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .req      (store_req)
    );

    // jal links the return address
    assign wb_data = dec.is_jal ? pc + 32'd4 : alu_result;

    // nothing retires once halted
    assign reg_we   = dec.reg_we & ~halted;
    assign store_en = dec.is_store & ~halted;
    assign ecall    = dec.is_ecall & ~halted;
    assign illegal  = dec.illegal & ~halted;

endmodule

/* hw/rv_mini_store.sv */
`timescale 1ns/1ps

module rv_mini_store (
    input  rv_mini_pkg::dec_t       dec,
    input  rv_mini_pkg::word_t      rs1_data,
    input  rv_mini_pkg::word_t      rs2_data,
    output rv_mini_pkg::store_req_t req
);

    rv_mini_pkg::word_t addr;
    logic [1:0]         lane;

    assign addr = rs1_data + dec.imm;
    assign lane = addr[1:0];

    always_comb begin
        req.addr  = addr;                        // word address comes from the environment
        req.wdata = rs2_data << {lane, 3'b000};  // move data into its byte lane
        case (dec.store_size)
            rv_mini_pkg::BYTE: req.wstrb = 4'b0001 << lane;
            // a misaligned half just lands where the address points
            rv_mini_pkg::HALF: req.wstrb = 4'b0011 << lane;
            default:           req.wstrb = 4'b1111;
        endcase
    end

endmodule

/* hw/rv_mini_fetch.sv */
`timescale 1ns/1ps

`include "rv_mini_params.svh"

module rv_mini_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_mini_pkg::dec_t  dec,
    output rv_mini_pkg::word_t pc,
    output logic               halted
);

    rv_mini_pkg::run_state_e state_q;
    rv_mini_pkg::run_state_e state_d;
    rv_mini_pkg::word_t      pc_q;
    rv_mini_pkg::word_t      pc_d;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        if (state_q == rv_mini_pkg::RUN) begin
            if (dec.is_ebreak) begin
                state_d = rv_mini_pkg::HALTED;  // pc stays on the ebreak
            end else if (dec.is_jal) begin
                pc_d = pc_q + dec.imm;
            end else begin
                pc_d = pc_q + 32'd4;  // ecall and illegal fall through too
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rv_mini_pkg::RUN;
            pc_q    <= `RV_MINI_RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign pc     = pc_q;
    assign halted = (state_q == rv_mini_pkg::HALTED);

endmodule

/* hw/rv_mini_alu.sv */
`timescale 1ns/1ps

module rv_mini_alu (
    input  rv_mini_pkg::dec_t  dec,
    input  rv_mini_pkg::word_t pc,
    input  rv_mini_pkg::word_t rs1_data,
    input  rv_mini_pkg::word_t rs2_data,
    output rv_mini_pkg::word_t result
);

    rv_mini_pkg::word_t a;
    rv_mini_pkg::word_t b;
    logic [4:0]         shamt;

    assign a     = dec.a_is_pc ? pc : rs1_data;
    assign b     = dec.b_is_imm ? dec.imm : rs2_data;
    assign shamt = b[4:0];  // upper bits ignored, srai flag included

    always_comb begin
        case (dec.alu_op)
            rv_mini_pkg::ADD:  result = a + b;
            rv_mini_pkg::SUB:  result = a - b;
            rv_mini_pkg::SLL:  result = a << shamt;
            rv_mini_pkg::SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_mini_pkg::SLTU: result = {31'b0, a < b};
            rv_mini_pkg::XOR:  result = a ^ b;
            rv_mini_pkg::SRL:  result = a >> shamt;
            rv_mini_pkg::SRA:  result = rv_mini_pkg::word_t'($signed(a) >>> shamt);
            rv_mini_pkg::OR:   result = a | b;
            rv_mini_pkg::AND:  result = a & b;
            default:           result = '0;
        endcase
    end

endmodule

/* hw/rv_mini_regfile.sv */
`timescale 1ns/1ps

`include "rv_mini_params.svh"

module rv_mini_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_mini_pkg::reg_idx_t rs1,
    input  rv_mini_pkg::reg_idx_t rs2,
    output rv_mini_pkg::word_t    rs1_data,
    output rv_mini_pkg::word_t    rs2_data,
    input  logic                  we,
    input  rv_mini_pkg::reg_idx_t rd,
    input  rv_mini_pkg::word_t    wdata
);

    rv_mini_pkg::word_t regs [`RV_MINI_NUM_REGS];

    // x0 is never written, so it reads back zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_MINI_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];  // combinational read
    assign rs2_data = regs[rs2];

endmodule

/* hw/rv_mini_decode.sv */
`timescale 1ns/1ps

module rv_mini_decode (
    input  rv_mini_pkg::word_t inst,
    output rv_mini_pkg::dec_t  dec
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_mini_pkg::word_t imm_i;
    rv_mini_pkg::word_t imm_s;
    rv_mini_pkg::word_t imm_u;
    rv_mini_pkg::word_t imm_j;
    rv_mini_pkg::alu_op_e op;
    logic               shift_ok;
    logic               r_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 picks the operation, bit 30 splits sub and sra
    always_comb begin
        case (funct3)
            3'b000:  op = (opcode == 7'b0110011 && inst[30]) ? rv_mini_pkg::SUB
                                                               : rv_mini_pkg::ADD;
            3'b001:  op = rv_mini_pkg::SLL;
            3'b010:  op = rv_mini_pkg::SLT;
            3'b011:  op = rv_mini_pkg::SLTU;
            3'b100:  op = rv_mini_pkg::XOR;
            3'b101:  op = inst[30] ? rv_mini_pkg::SRA : rv_mini_pkg::SRL;
            3'b110:  op = rv_mini_pkg::OR;
            default: op = rv_mini_pkg::AND;
        endcase
    end

    // immediate shifts carry funct7 in the imm field
    assign shift_ok = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                      (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
    assign r_ok     = (funct7 == 7'h00) ||
                      (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        dec            = '0;
        dec.cls        = rv_mini_pkg::CLS_X;
        dec.alu_op     = op;
        dec.rd         = inst[11:7];
        dec.rs1        = inst[19:15];
        dec.rs2        = inst[24:20];
        dec.store_size = rv_mini_pkg::store_size_e'(funct3[1:0]);
        case (opcode)
            7'b0010011: begin // addi .. srai
                dec.cls      = rv_mini_pkg::CLS_I;
                dec.imm      = imm_i;
                dec.b_is_imm = 1'b1;
                dec.reg_we   = shift_ok;
                dec.illegal  = !shift_ok;
            end
            7'b1110011: begin
                dec.cls       = rv_mini_pkg::CLS_N;
                dec.is_ecall  = (inst[31:7] == 25'h0000000);
                dec.is_ebreak = (inst[31:7] == 25'h0002000);
                dec.illegal   = !(dec.is_ecall || dec.is_ebreak);
            end
            7'b0110111, 7'b0010111: begin // lui, auipc
                dec.cls      = rv_mini_pkg::CLS_U;
                dec.alu_op   = rv_mini_pkg::ADD;
                dec.imm      = imm_u;
                dec.b_is_imm = 1'b1;
                dec.a_is_pc  = opcode[5] ? 1'b0 : 1'b1;
                dec.rs1      = opcode[5] ? 5'd0 : inst[19:15];  // lui adds to x0
                dec.reg_we   = 1'b1;
            end
            7'b0110011: begin
                dec.cls     = rv_mini_pkg::CLS_R;
                dec.reg_we  = r_ok;
                dec.illegal = !r_ok;
            end
            7'b0100011: begin // sb sh sw
                dec.cls      = rv_mini_pkg::CLS_S;
                dec.imm      = imm_s;
                dec.is_store = (funct3 <= 3'b010);
                dec.illegal  = (funct3 > 3'b010);
            end
            7'b1101111: begin
                dec.cls    = rv_mini_pkg::CLS_J;
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.reg_we = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

/* hw/rv_mini_pkg.sv */
package rv_mini_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  reg_idx_t;

    // fixed class codes, 6 left unused
    typedef enum logic [2:0] {
        CLS_I = 3'd0,
        CLS_N = 3'd1,
        CLS_U = 3'd2,
        CLS_R = 3'd3,
        CLS_S = 3'd4,
        CLS_J = 3'd5,
        CLS_X = 3'd7     // unknown opcode
    } inst_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // same encoding as funct3 of sb/sh/sw
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } store_size_e;

    typedef enum logic {
        RUN    = 1'b0,
        HALTED = 1'b1
    } run_state_e;

    typedef struct packed {
        inst_class_e cls;
        alu_op_e     alu_op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       imm;
        logic        reg_we;
        logic        a_is_pc;     // operand a from pc (auipc)
        logic        b_is_imm;    // operand b from imm
        logic        is_store;
        logic        is_jal;
        logic        is_ecall;
        logic        is_ebreak;
        logic        illegal;
        store_size_e store_size;
    } dec_t;

    typedef struct packed {
        word_t      addr;     // byte address, not aligned
        word_t      wdata;    // already shifted into its lanes
        logic [3:0] wstrb;
    } store_req_t;

endpackage

/* hw/rv_mini_params.svh */
`ifndef RV_MINI_PARAMS_SVH
`define RV_MINI_PARAMS_SVH

// first fetch address out of reset
`define RV_MINI_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define RV_MINI_NUM_REGS 32

`endif
